// ==== sim.f ====
hdl/i2c_cfg_pkg.sv
hdl/frame_if.sv
hdl/line_filter.sv
hdl/phase_timer.sv
hdl/frame_shifter.sv
hdl/transfer_ctrl.sv
hdl/i2c_cfg_master.sv
verif/i2c_cfg_assertions.sv
verif/i2c_slave_model.sv
verif/tb_i2c_cfg_master.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_i2c_cfg_master \
    -o tb_i2c_cfg_master

out=$(./obj_dir/tb_i2c_cfg_master)
echo "$out"

if echo "$out" | grep -q '^>>> PASS$'; then
    exit 0
fi
exit 1

// ==== verif/golden_vectors.txt ====
// op addr reg wdata ackmask rdbyte exp_rdata exp_flags, all hex
// op: 0 write, 1 read, 2 write with a stray request while busy
// ackmask {addr,reg,data} 1 = slave acks, flags {valid,nack_slave,nack_addr,nack_data}
0 3c 12 a5 7 00 00 0
1 3c 12 00 7 5a 5a 8
0 21 30 0f 3 00 00 4
0 21 31 f0 5 00 00 2
0 21 32 66 6 00 00 1
1 21 44 00 3 c3 c3 c
1 21 45 00 5 96 96 a
1 21 46 00 6 3c 3c 8
2 50 7f e1 7 00 00 0
1 50 7f 00 7 81 81 8

// ==== verif/tb_i2c_cfg_master.sv ====
// i2c config master testbench
`timescale 1ns/1ns

module tb_i2c_cfg_master;
    import i2c_cfg_pkg::*;

    localparam int TIMEOUT_CYCLES = 200000;
    localparam int RESET_CYCLES   = 16;

    logic        clk;
    logic        rstn;
    logic        wr, rd;
    slave_addr_t slave_addr;
    reg_addr_t   reg_addr;
    data_t       wdata;
    data_t       rdata;
    logic        busy, rdata_valid;
    logic        nack_slave, nack_addr, nack_data;
    logic        m_scl, m_sda;      // master release outputs
    logic        s_scl, s_sda;      // slave release outputs
    logic        scl_bus, sda_bus;  // open drain wired and
    logic [2:0]  ack_mask;
    data_t       rd_byte;
    slave_addr_t seen_addr;         // what the slave received
    logic        seen_rw;
    reg_addr_t   seen_reg;
    data_t       seen_data;
    int          seen_starts;
    int          errors, test_errors, tests;
    bit          hung;

    assign scl_bus = m_scl & s_scl;
    assign sda_bus = m_sda & s_sda;

    initial clk = 1'b0;
    always #20 clk = ~clk;  // 40 ns

    i2c_cfg_master i2c_cfg_master_inst (
        .i_clk (clk), .i_rstn (rstn), .i_wr (wr), .i_rd (rd),
        .i_slave_addr (slave_addr), .i_reg_addr (reg_addr), .i_wdata (wdata),
        .o_rdata (rdata), .o_busy (busy), .o_rdata_valid (rdata_valid),
        .o_nack_slave (nack_slave), .o_nack_addr (nack_addr), .o_nack_data (nack_data),
        .i_scl (scl_bus), .i_sda (sda_bus), .o_scl (m_scl), .o_sda (m_sda)
    );

    i2c_slave_model slave_inst (
        .i_clk (clk), .i_rstn (rstn), .i_scl (scl_bus), .i_sda (sda_bus),
        .i_ack_mask (ack_mask), .i_rd_byte (rd_byte), .o_scl (s_scl), .o_sda (s_sda),
        .o_addr (seen_addr), .o_rw (seen_rw), .o_reg (seen_reg), .o_data (seen_data),
        .o_starts (seen_starts)
    );

    bind i2c_cfg_master i2c_cfg_assertions assertions_inst (
        .i_clk (i_clk), .i_rstn (i_rstn), .i_wr (i_wr), .i_rd (i_rd),
        .i_scl (i_scl), .i_sda (i_sda), .o_sda (o_sda), .o_busy (o_busy),
        .o_rdata_valid (o_rdata_valid), .o_nack_slave (o_nack_slave),
        .o_nack_addr (o_nack_addr), .o_nack_data (o_nack_data)
    );

    task automatic check_data(input string name, input data_t exp, input data_t got);
        if (got !== exp) begin
            $display("Error: %s expected %h got %h", name, exp, got);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("Error: %s expected %h got %h", name, exp, got);
            test_errors++;
        end
    endtask

    // polls at negedge, where outputs are settled
    task automatic wait_busy(input logic level, input string what);
        int n;
        n = 0;
        while (busy !== level && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (busy !== level) begin
            $display("timeout: o_busy never went to %0d %s", level, what);
            hung = 1'b1;
            test_errors++;
        end
    endtask

    function automatic string op_name(input logic [3:0] op);
        case (op)
            4'h0:    return "write";
            4'h1:    return "read";
            4'h2:    return "write, request while busy";
            default: return "unknown";
        endcase
    endfunction

    task automatic run_vector(input logic [3:0] op, input slave_addr_t a,
                              input reg_addr_t r, input data_t d, input logic [2:0] mask,
                              input data_t rb, input data_t exp_rdata,
                              input logic [3:0] exp_flags);
        int   starts0;
        logic is_read;
        is_read = (op == 4'h1);
        starts0 = seen_starts;
        if (op > 4'h2) begin
            $display("bad operation code %h in golden file", op);
            test_errors++;
            return;
        end
        @(posedge clk);
        #2;
        slave_addr = a;
        reg_addr   = r;
        wdata      = d;
        ack_mask   = mask;
        rd_byte    = rb;
        wr         = !is_read;
        rd         = is_read;
        @(posedge clk);  // accepted here, dut idle
        #2;
        wr = 1'b0;
        rd = 1'b0;
        wait_busy(1'b1, "after the request");
        if (hung)
            return;
        if (op == 4'h2) begin  // stray read, must be dropped
            repeat (50) @(posedge clk);
            #2;
            rd       = 1'b1;
            reg_addr = ~r;
            @(posedge clk);
            #2;
            rd = 1'b0;
        end
        wait_busy(1'b0, "at the end of the transfer");
        if (hung)
            return;
        check_flag("o_rdata_valid", exp_flags[3], rdata_valid);
        check_flag("o_nack_slave", exp_flags[2], nack_slave);
        check_flag("o_nack_addr", exp_flags[1], nack_addr);
        check_flag("o_nack_data", exp_flags[0], nack_data);
        if (is_read)
            check_data("o_rdata", exp_rdata, rdata);
        check_data("slave address", {1'b0, a}, {1'b0, seen_addr});
        check_flag("slave rw bit", is_read, seen_rw);
        check_data("slave register", r, seen_reg);
        if (!is_read)
            check_data("slave write data", d, seen_data);
        // one start per write, two per read
        check_data("start count", data_t'(is_read ? 2 : 1), data_t'(seen_starts - starts0));
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [3:0]  op;
        slave_addr_t a;
        reg_addr_t   r;
        data_t       d, rb, er;
        logic [2:0]  mask;
        logic [3:0]  ef;
        rstn       = 1'b0;
        wr         = 1'b0;
        rd         = 1'b0;
        slave_addr = '0;
        reg_addr   = '0;
        wdata      = '0;
        ack_mask   = 3'b111;
        rd_byte    = '0;
        errors     = 0;
        tests      = 0;
        hung       = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rstn = 1'b1;

        // reset state and init wait
        test_errors = 0;
        wait_busy(1'b0, "after reset");
        check_flag("o_rdata_valid", 1'b0, rdata_valid);
        check_flag("o_nack_slave", 1'b0, nack_slave);
        check_flag("o_nack_addr", 1'b0, nack_addr);
        check_flag("o_nack_data", 1'b0, nack_data);
        check_flag("o_scl", 1'b1, m_scl);
        check_flag("o_sda", 1'b1, m_sda);
        $display("test %0d reset: %s", tests, test_errors == 0 ? "ok" : "failed");
        errors += test_errors;
        tests++;

        fd = $fopen("verif/golden_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/golden_vectors.txt");
            errors++;
        end else begin
            while (!hung && !$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%h %h %h %h %h %h %h %h", op, a, r, d, mask, rb, er, ef);
                if (n == 8) begin  // comment and blank lines fall out here
                    test_errors = 0;
                    run_vector(op, a, r, d, mask, rb, er, ef);
                    $display("test %0d %s: %s", tests, op_name(op),
                             test_errors == 0 ? "ok" : "failed");
                    errors += test_errors;
                    tests++;
                end
            end
            $fclose(fd);
            if (tests < 2) begin
                $display("golden file held no vectors");
                errors++;
            end
        end

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0 && !hung)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== verif/i2c_slave_model.sv ====
// behavioral i2c target
`timescale 1ns/1ns

module i2c_slave_model (
    input  logic                     i_clk,
    input  logic                     i_rstn,
    input  logic                     i_scl,       // bus levels
    input  logic                     i_sda,
    input  logic [2:0]               i_ack_mask,  // {addr, reg, data} where 1 acks
    input  i2c_cfg_pkg::data_t       i_rd_byte,   // byte returned on reads
    output logic                     o_scl,       // 1 releases the line
    output logic                     o_sda,
    output i2c_cfg_pkg::slave_addr_t o_addr,      // last address frame
    output logic                     o_rw,
    output i2c_cfg_pkg::reg_addr_t   o_reg,
    output i2c_cfg_pkg::data_t       o_data,
    output int                       o_starts     // start conditions seen
);
    import i2c_cfg_pkg::*;

    logic       scl_q, sda_q;  // previous bus samples
    int         rise_cnt;      // scl rising edges since start
    int         stretch;       // clocks left holding scl low
    logic [7:0] sr;

    assign o_scl = (stretch == 0);

    // level to put on sda for bit k counted from start
    function automatic logic drive_level(input int k);
        data_t sh;
        sh = i_rd_byte << (k - 9);
        if (k == 8)
            return !i_ack_mask[2];  // low acks the address
        if (!o_rw) begin
            if (k == 17)
                return !i_ack_mask[1];
            if (k == 26)
                return !i_ack_mask[0];
            return 1'b1;
        end
        if (k >= 9 && k <= 16)
            return sh[7];  // read byte msb first
        return 1'b1;       // master ack slot and trailing bits
    endfunction

    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            scl_q    <= 1'b1;
            sda_q    <= 1'b1;
            rise_cnt <= 0;
            stretch  <= 0;
            sr       <= '0;
            o_sda    <= 1'b1;
            o_addr   <= '0;
            o_rw     <= 1'b0;
            o_reg    <= '0;
            o_data   <= '0;
            o_starts <= 0;
        end else begin
            scl_q <= i_scl;
            sda_q <= i_sda;
            if (stretch != 0)
                stretch <= stretch - 1;
            if (scl_q && i_scl && sda_q && !i_sda) begin  // start
                rise_cnt <= 0;
                o_starts <= o_starts + 1;
            end else if (!scl_q && i_scl) begin  // scl rise takes the bit
                rise_cnt <= rise_cnt + 1;
                sr       <= {sr[6:0], i_sda};
                case (rise_cnt)
                    7: begin
                        o_addr <= sr[6:0];
                        o_rw   <= i_sda;
                    end
                    16: if (!o_rw) o_reg <= {sr[6:0], i_sda};
                    25: if (!o_rw) o_data <= {sr[6:0], i_sda};
                    default: ;
                endcase
            end else if (scl_q && !i_scl) begin  // scl fall drives the next bit
                o_sda <= drive_level(rise_cnt);
                if (rise_cnt == 9)  // hold scl past the master's low phase
                    stretch <= T_HD_DAT + T_LOW + T_HIGH;
            end
        end
    end

endmodule

// ==== verif/i2c_cfg_assertions.sv ====
// bus and status checks
`timescale 1ns/1ns

module i2c_cfg_assertions (
    input logic i_clk,
    input logic i_rstn,
    input logic i_wr,
    input logic i_rd,
    input logic i_scl,          // bus levels at the dut pins
    input logic i_sda,
    input logic o_sda,          // master release output
    input logic o_busy,
    input logic o_rdata_valid,
    input logic o_nack_slave,
    input logic o_nack_addr,
    input logic o_nack_data
);
    import i2c_cfg_pkg::*;

    logic [3:0] flags;
    int         scl_high_cnt;  // samples since scl went high, saturates

    assign flags = {o_rdata_valid, o_nack_slave, o_nack_addr, o_nack_data};

    always_ff @(posedge i_clk) begin
        if (!i_rstn || !i_scl)
            scl_high_cnt <= 0;
        else if (scl_high_cnt < T_SU_STO)
            scl_high_cnt <= scl_high_cnt + 1;
    end

    // sda moves under high scl only for a master start or stop
    // and only after a full setup time of high scl
    sda_scl_high: assert property (
        @(posedge i_clk) disable iff (!i_rstn)
        (i_scl && $changed(i_sda)) |-> ($changed(o_sda) && scl_high_cnt >= T_SU_STO)
    ) else $error("sda changed while scl high outside start or stop");

    busy_on_accept: assert property (
        @(posedge i_clk) disable iff (!i_rstn)
        ((i_wr || i_rd) && !o_busy) |=> o_busy
    ) else $error("o_busy not raised after an accepted request");

    // flags already final when busy drops
    flags_at_done: assert property (
        @(posedge i_clk) disable iff (!i_rstn)
        $fell(o_busy) |-> $stable(flags)
    ) else $error("status flags moved as o_busy fell");

    flags_hold_idle: assert property (
        @(posedge i_clk) disable iff (!i_rstn)
        (!o_busy && !i_wr && !i_rd) |=> $stable(flags)
    ) else $error("status flags moved while idle");

endmodule

// ==== hdl/i2c_cfg_master.sv ====
// camera config i2c master
`timescale 1ns/1ns

module i2c_cfg_master (
    input  logic                     i_clk,          // 100 MHz
    input  logic                     i_rstn,
    input  logic                     i_wr,           // write request
    input  logic                     i_rd,           // read request
    input  i2c_cfg_pkg::slave_addr_t i_slave_addr,
    input  i2c_cfg_pkg::reg_addr_t   i_reg_addr,
    input  i2c_cfg_pkg::data_t       i_wdata,
    output i2c_cfg_pkg::data_t       o_rdata,
    output logic                     o_busy,
    output logic                     o_rdata_valid,
    output logic                     o_nack_slave,   // no ack on address
    output logic                     o_nack_addr,    // no ack on register
    output logic                     o_nack_data,    // no ack on write data
    input  logic                     i_scl,
    input  logic                     i_sda,
    output logic                     o_scl,          // 1 releases the pin
    output logic                     o_sda
);
    import i2c_cfg_pkg::*;

    logic        req_wr, req_rd, accept;
    logic        r_is_read;
    slave_addr_t r_slave_addr;
    reg_addr_t   r_reg_addr;
    data_t       r_wdata;
    logic        scl_f, sda_f;
    logic        tmr_load, tmr_done;
    timer_t      tmr_value;

    frame_if fr_bus ();

    // only taken while idle, no queue behind it
    assign req_wr = i_wr & ~o_busy;
    assign req_rd = i_rd & ~o_busy;
    assign accept = req_wr | req_rd;

    always_ff @(posedge i_clk) begin
        if (!i_rstn)
            r_is_read <= 1'b0;
        else if (accept)
            r_is_read <= i_rd;
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin  // held for the whole transfer
            r_slave_addr <= i_slave_addr;
            r_reg_addr   <= i_reg_addr;
            r_wdata      <= i_wdata;
        end
    end

    line_filter line_filter_inst (
        .i_clk   (i_clk),
        .i_rstn  (i_rstn),
        .i_scl   (i_scl),
        .i_sda   (i_sda),
        .o_scl_f (scl_f),
        .o_sda_f (sda_f)
    );

    phase_timer phase_timer_inst (
        .i_clk   (i_clk),
        .i_rstn  (i_rstn),
        .i_load  (tmr_load),
        .i_value (tmr_value),
        .o_done  (tmr_done)
    );

    frame_shifter frame_shifter_inst (
        .i_clk        (i_clk),
        .i_rstn       (i_rstn),
        .i_slave_addr (r_slave_addr),
        .i_reg_addr   (r_reg_addr),
        .i_wdata      (r_wdata),
        .fr           (fr_bus)
    );

    transfer_ctrl transfer_ctrl_inst (
        .i_clk         (i_clk),
        .i_rstn        (i_rstn),
        .i_req_wr      (req_wr),
        .i_req_rd      (req_rd),
        .i_is_read     (r_is_read),
        .i_scl_f       (scl_f),
        .i_sda_f       (sda_f),
        .fr            (fr_bus),
        .o_tmr_load    (tmr_load),
        .o_tmr_value   (tmr_value),
        .i_tmr_done    (tmr_done),
        .o_scl         (o_scl),
        .o_sda         (o_sda),
        .o_busy        (o_busy),
        .o_rdata_valid (o_rdata_valid),
        .o_nack_slave  (o_nack_slave),
        .o_nack_addr   (o_nack_addr),
        .o_nack_data   (o_nack_data),
        .o_rdata       (o_rdata)
    );

endmodule

// ==== hdl/transfer_ctrl.sv ====
// i2c transfer sequencer
`timescale 1ns/1ns

module transfer_ctrl (
    input  logic                i_clk,
    input  logic                i_rstn,
    input  logic                i_req_wr,     // accepted write
    input  logic                i_req_rd,     // accepted read
    input  logic                i_is_read,    // latched request type
    input  logic                i_scl_f,
    input  logic                i_sda_f,
    frame_if.ctrl               fr,
    output logic                o_tmr_load,
    output i2c_cfg_pkg::timer_t o_tmr_value,
    input  logic                i_tmr_done,
    output logic                o_scl,        // 1 releases the line
    output logic                o_sda,
    output logic                o_busy,
    output logic                o_rdata_valid,
    output logic                o_nack_slave,
    output logic                o_nack_addr,
    output logic                o_nack_data,
    output i2c_cfg_pkg::data_t  o_rdata
);
    import i2c_cfg_pkg::*;

    ctrl_state_t state, nxt_state;
    ctrl_state_t ret_state, nxt_ret_state;  // where a timed wait returns

    logic     first_phase, nxt_first_phase;  // read: register write part
    logic     nxt_scl, nxt_sda;
    logic     nxt_busy, nxt_rdata_valid;
    logic     nxt_nack_slave, nxt_nack_addr, nxt_nack_data;
    logic     rdata_cap;
    logic     accept;
    bit_cnt_t end_idx;

    assign accept  = i_req_wr | i_req_rd;
    assign end_idx = i_is_read ? bit_cnt_t'(18) : bit_cnt_t'(27);  // extra low bit before stop
    assign fr.sda_s = i_sda_f;
    assign fr.kind  = !i_is_read ? FRAME_WR :
                      first_phase ? FRAME_RD_ADDR : FRAME_RD_DATA;

    always_comb begin
        nxt_state       = state;
        nxt_ret_state   = ret_state;
        nxt_first_phase = first_phase;
        nxt_scl         = o_scl;
        nxt_sda         = o_sda;
        nxt_busy        = o_busy;
        nxt_rdata_valid = o_rdata_valid;
        nxt_nack_slave  = o_nack_slave;
        nxt_nack_addr   = o_nack_addr;
        nxt_nack_data   = o_nack_data;
        rdata_cap       = 1'b0;
        fr.load         = 1'b0;
        fr.shift        = 1'b0;
        fr.sample       = 1'b0;
        o_tmr_load      = 1'b0;
        o_tmr_value     = '0;

        case (state)
            ST_INIT: begin  // bus released for a start setup time
                nxt_busy      = 1'b1;
                nxt_scl       = 1'b1;
                nxt_sda       = 1'b1;
                o_tmr_load    = 1'b1;
                o_tmr_value   = timer_t'(T_SU_STA);
                nxt_ret_state = ST_IDLE;
                nxt_state     = ST_WAIT;
            end
            ST_IDLE: begin
                nxt_scl  = 1'b1;
                nxt_sda  = 1'b1;
                nxt_busy = 1'b0;
                if (accept) begin
                    nxt_busy        = 1'b1;
                    nxt_rdata_valid = 1'b0;  // status cleared per request
                    nxt_nack_slave  = 1'b0;
                    nxt_nack_addr   = 1'b0;
                    nxt_nack_data   = 1'b0;
                    nxt_first_phase = 1'b1;
                    nxt_state       = ST_START;
                end
            end
            ST_START: begin  // sda falls while scl high
                nxt_sda = 1'b0;
                fr.load = 1'b1;
                if (!i_sda_f) begin
                    o_tmr_load    = 1'b1;
                    o_tmr_value   = timer_t'(T_HD_STA);
                    nxt_ret_state = ST_BIT_LOW;
                    nxt_state     = ST_WAIT;
                end
            end
            ST_BIT_LOW: begin
                nxt_scl = 1'b0;
                if (!i_scl_f) begin  // scl seen low
                    o_tmr_load    = 1'b1;
                    o_tmr_value   = timer_t'(T_HD_DAT);
                    nxt_ret_state = ST_BIT_DRIVE;
                    nxt_state     = ST_WAIT;
                end
            end
            ST_BIT_DRIVE: begin  // sda only changes here, scl low
                nxt_sda       = fr.tx_bit;
                fr.shift      = 1'b1;
                o_tmr_load    = 1'b1;
                o_tmr_value   = timer_t'(T_LOW);
                nxt_ret_state = ST_BIT_HIGH;
                nxt_state     = ST_WAIT;
            end
            ST_BIT_HIGH: begin
                nxt_scl = 1'b1;
                if (i_scl_f) begin  // held here while target stretches scl
                    fr.sample  = 1'b1;
                    o_tmr_load = 1'b1;
                    nxt_state  = ST_WAIT;
                    if (fr.bit_cnt == bit_cnt_t'(8))
                        nxt_nack_slave = o_nack_slave | i_sda_f;
                    else if (fr.bit_cnt == bit_cnt_t'(17) && (!i_is_read || first_phase))
                        nxt_nack_addr = o_nack_addr | i_sda_f;
                    else if (fr.bit_cnt == bit_cnt_t'(26))
                        nxt_nack_data = o_nack_data | i_sda_f;  // writes only get here

                    if (fr.bit_cnt == end_idx) begin
                        o_tmr_value   = timer_t'(T_SU_STO);
                        nxt_ret_state = ST_STOP;
                    end else begin
                        o_tmr_value   = timer_t'(T_HIGH);
                        nxt_ret_state = ST_BIT_LOW;
                    end
                end
            end
            ST_STOP: begin  // sda rises while scl high
                nxt_sda = 1'b1;
                if (i_sda_f) begin
                    o_tmr_load = 1'b1;
                    nxt_state  = ST_WAIT;
                    if (i_is_read && first_phase) begin
                        nxt_first_phase = 1'b0;  // go on to the data phase
                        o_tmr_value     = timer_t'(T_SU_STA - T_SU_STO);
                        nxt_ret_state   = ST_START;
                    end else begin
                        rdata_cap       = i_is_read;
                        nxt_rdata_valid = i_is_read;
                        o_tmr_value     = timer_t'(T_SU_STA);
                        nxt_ret_state   = ST_IDLE;
                    end
                end
            end
            ST_WAIT: begin
                if (i_tmr_done)
                    nxt_state = ret_state;
            end
            default: nxt_state = ST_INIT;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            state         <= ST_INIT;
            ret_state     <= ST_IDLE;
            first_phase   <= 1'b0;
            o_scl         <= 1'b1;  // released
            o_sda         <= 1'b1;
            o_busy        <= 1'b1;  // until init wait ends
            o_rdata_valid <= 1'b0;
            o_nack_slave  <= 1'b0;
            o_nack_addr   <= 1'b0;
            o_nack_data   <= 1'b0;
        end else begin
            state         <= nxt_state;
            ret_state     <= nxt_ret_state;
            first_phase   <= nxt_first_phase;
            o_scl         <= nxt_scl;
            o_sda         <= nxt_sda;
            o_busy        <= nxt_busy;
            o_rdata_valid <= nxt_rdata_valid;
            o_nack_slave  <= nxt_nack_slave;
            o_nack_addr   <= nxt_nack_addr;
            o_nack_data   <= nxt_nack_data;
        end
    end

    // read byte, captured at final stop
    always_ff @(posedge i_clk) begin
        if (rdata_cap)
            o_rdata <= fr.rx_byte;
    end

endmodule

// ==== hdl/frame_shifter.sv ====
// i2c frame tx queue and rx shift register
`timescale 1ns/1ns

module frame_shifter (
    input  logic                     i_clk,
    input  logic                     i_rstn,
    input  i2c_cfg_pkg::slave_addr_t i_slave_addr,
    input  i2c_cfg_pkg::reg_addr_t   i_reg_addr,
    input  i2c_cfg_pkg::data_t       i_wdata,
    frame_if.shifter                 fr
);
    import i2c_cfg_pkg::*;

    logic [FRAME_BITS-1:0] queue;      // msb goes out first
    logic [FRAME_BITS-1:0] frame_img;  // frame picked by kind
    logic                  rx_window;  // bit index inside the data byte

    // 1'b1 slots are released for the far side to drive
    always_comb begin
        case (fr.kind)
            FRAME_WR: begin
                frame_img = {i_slave_addr, 1'b0, 1'b1,  // addr, write, ack
                             i_reg_addr, 1'b1,          // reg, ack
                             i_wdata, 1'b1};            // data, ack
            end
            FRAME_RD_ADDR: begin
                frame_img = {i_slave_addr, 1'b0, 1'b1,  // addr, write, ack
                             i_reg_addr, 1'b1,          // reg, ack
                             9'b0};                     // low into stop
            end
            FRAME_RD_DATA: begin
                frame_img = {i_slave_addr, 1'b1, 1'b1,  // addr, read, ack
                             8'hff, 1'b1,               // slave data, master nack
                             9'b0};                     // low into stop
            end
            default: frame_img = '1;
        endcase
    end

    // tx queue, zero fill keeps sda low ahead of stop
    always_ff @(posedge i_clk) begin
        if (fr.load)
            queue <= frame_img;
        else if (fr.shift)
            queue <= {queue[FRAME_BITS-2:0], 1'b0};
    end

    assign fr.tx_bit = queue[FRAME_BITS-1];

    // bit index of the next sample
    always_ff @(posedge i_clk) begin
        if (!i_rstn)
            fr.bit_cnt <= '0;
        else if (fr.load)
            fr.bit_cnt <= '0;
        else if (fr.sample)
            fr.bit_cnt <= fr.bit_cnt + bit_cnt_t'(1);
    end

    // data byte sits at indexes 9..16 after address and ack
    assign rx_window = (fr.bit_cnt >= bit_cnt_t'(9)) && (fr.bit_cnt <= bit_cnt_t'(16));

    always_ff @(posedge i_clk) begin
        if (fr.sample && rx_window)
            fr.rx_byte <= {fr.rx_byte[6:0], fr.sda_s};  // msb first
    end

endmodule

// ==== hdl/phase_timer.sv ====
// bus phase down-counter
`timescale 1ns/1ns

module phase_timer (
    input  logic                i_clk,
    input  logic                i_rstn,
    input  logic                i_load,   // start a new phase
    input  i2c_cfg_pkg::timer_t i_value,  // phase length in clocks
    output logic                o_done
);
    import i2c_cfg_pkg::*;

    timer_t count;

    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            count <= '0;  // idle, reads as done
        end else if (i_load) begin
            count <= i_value;
        end else if (count != '0) begin
            count <= count - timer_t'(1);  // stops at zero
        end
    end

    // done at two, one clock is spent entering the wait
    // and one leaving it
    assign o_done = (count <= timer_t'(2));

endmodule

// ==== hdl/line_filter.sv ====
// scl and sda glitch filter
`timescale 1ns/1ns

module line_filter (
    input  logic i_clk,
    input  logic i_rstn,
    input  logic i_scl,
    input  logic i_sda,
    output logic o_scl_f,
    output logic o_sda_f
);
    import i2c_cfg_pkg::*;

    localparam int LINES = 2;  // [1] scl, [0] sda

    logic [LINES-1:0]                   line_in;
    logic [LINES-1:0][FILTER_DEPTH-1:0] samp_sr;  // sample history per line
    logic [LINES-1:0]                   line_f;   // filtered levels

    assign line_in = {i_scl, i_sda};

    // output only moves once every sample agrees
    // 4 samples + output reg -> 5 cycles latency
    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            samp_sr <= '1;  // bus idles high
            line_f  <= '1;
        end else begin
            for (int i = 0; i < LINES; i++) begin
                samp_sr[i] <= {samp_sr[i][FILTER_DEPTH-2:0], line_in[i]};
                if (&samp_sr[i])
                    line_f[i] <= 1'b1;
                else if (~|samp_sr[i])
                    line_f[i] <= 1'b0;  // mixed samples hold last level
            end
        end
    end

    assign o_scl_f = line_f[1];
    assign o_sda_f = line_f[0];

endmodule

// ==== hdl/frame_if.sv ====
// controller to frame shifter link
`timescale 1ns/1ns

interface frame_if;
    import i2c_cfg_pkg::*;

    // controller side
    logic        load;     // reload queue, clear bit count
    frame_kind_t kind;     // frame to build on load
    logic        shift;    // pop queue head
    logic        sample;   // count a bit, capture sda_s
    logic        sda_s;    // filtered sda level

    // shifter side
    logic        tx_bit;   // queue head
    bit_cnt_t    bit_cnt;  // bits sampled in this frame
    data_t       rx_byte;  // received data byte

    modport ctrl (
        output load, kind, shift, sample, sda_s,
        input  tx_bit, bit_cnt, rx_byte
    );

    modport shifter (
        input  load, kind, shift, sample, sda_s,
        output tx_bit, bit_cnt, rx_byte
    );

endinterface

// ==== hdl/i2c_cfg_pkg.sv ====
// i2c config master definitions
package i2c_cfg_pkg;

    localparam int CLK_PERIOD_NS = 10;  // 100 MHz

    // standard mode phase lengths in clocks
    localparam int T_SU_STA = 4700 / CLK_PERIOD_NS;  // start setup
    localparam int T_HD_STA = 4000 / CLK_PERIOD_NS;  // start hold
    localparam int T_LOW    = 4700 / CLK_PERIOD_NS;  // scl low
    localparam int T_HIGH   = 4000 / CLK_PERIOD_NS;  // scl high
    localparam int T_HD_DAT = 5000 / CLK_PERIOD_NS;  // data hold, longest phase
    localparam int T_SU_STO = 4000 / CLK_PERIOD_NS;  // stop setup

    localparam int FRAME_BITS   = 27;  // addr + reg + data, each with ack
    localparam int FILTER_DEPTH = 4;   // samples that must agree

    localparam int TIMER_W = $clog2(T_HD_DAT + 1);

    typedef logic [6:0]         slave_addr_t;
    typedef logic [7:0]         reg_addr_t;
    typedef logic [7:0]         data_t;
    typedef logic [TIMER_W-1:0] timer_t;
    typedef logic [4:0]         bit_cnt_t;  // 0..27

    // what the tx queue gets loaded with
    typedef enum logic [1:0] {
        FRAME_WR,       // addr/w, reg, data
        FRAME_RD_ADDR,  // addr/w, reg
        FRAME_RD_DATA   // addr/r, released data byte
    } frame_kind_t;

    typedef enum logic [2:0] {
        ST_INIT,
        ST_IDLE,
        ST_START,
        ST_BIT_LOW,    // pull scl low
        ST_BIT_DRIVE,  // put next bit on sda
        ST_BIT_HIGH,   // release scl, sample
        ST_STOP,
        ST_WAIT        // timed wait, then back to ret state
    } ctrl_state_t;

endpackage
